// File: adc_capture.sv
`timescale 1ns/1ps

module adc_capture (
    input  logic              ADA_DCO,
    input  logic              hps_fpga_reset_n,
    input  dcc_pkg::adc_raw_t ada_d,
    input  dcc_pkg::adc_raw_t adb_d,
    output dcc_pkg::sample_t  a_mag,
    output logic              a_valid,
    output dcc_pkg::sample_t  b_mag,
    output logic              b_valid
);
    import dcc_pkg::*;

    logic a_neg, b_neg;

    assign a_neg = int'(ada_d) >= NEG_LIMIT;
    assign b_neg = int'(adb_d) >= NEG_LIMIT;

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            a_mag   <= '0;
            a_valid <= 1'b0;
            b_mag   <= '0;
            b_valid <= 1'b0;
        end
        else
        begin
            a_valid <= a_neg;
            b_valid <= b_neg;
            if (a_neg) a_mag <= sample_t'(FULL_SCALE - int'(ada_d));
            if (b_neg) b_mag <= sample_t'(FULL_SCALE - int'(adb_d));
        end
    end
endmodule

// File: dcc_pkg.sv
package dcc_pkg;

    // ========================================
    // converter and conditioning
    // ========================================
    localparam int ADC_BITS   = 14;
    localparam int NEG_LIMIT  = 8192;     // codes at or above are negative
    localparam int FULL_SCALE = 16384;    // magnitude = FULL_SCALE - code

    // history taps, index 0 is newest
    localparam int HIST_DEPTH = 104;
    localparam int TAIL_TAP   = 1;
    localparam int PEAK_TAP   = HIST_DEPTH - 2;

    // trigger gates
    localparam int PEAK_THRESHOLD = 3120; // scaled peak must exceed this
    localparam int PEAK_MAX       = 8000; // at or above -> stored as zero
    localparam int CH_A_GAIN      = 1;
    localparam int CH_B_GAIN      = 12;
    localparam int DEAD_SAMPLES   = 1000;
    localparam int DEAD_BITS      = $clog2(DEAD_SAMPLES + 2);  // holds the saturation value

    // timestamp and host words
    localparam int TICK_WRAP = 49999999;  // last count before wrap
    localparam int TICK_BITS = 26;
    localparam int WORD_BITS = 32;
    localparam int CH_B_LSB  = 16;        // channel b field in packed words

    // ========================================
    // types
    // ========================================
    typedef logic [ADC_BITS-1:0]  adc_raw_t;
    typedef logic [ADC_BITS-1:0]  sample_t;
    typedef logic [TICK_BITS-1:0] tick_t;
    typedef logic [WORD_BITS-1:0] word_t;

endpackage

// File: dcc_trigger_top.sv
`timescale 1ns/1ps

module dcc_trigger_top (
    input  logic              ADA_DCO,
    input  logic              hps_fpga_reset_n,
    input  dcc_pkg::adc_raw_t ada_d,
    input  dcc_pkg::adc_raw_t adb_d,
    input  logic              read_req,
    output logic              read_ack,
    output dcc_pkg::word_t    peak_word,
    output dcc_pkg::word_t    tail_word,
    output dcc_pkg::tick_t    time_word
);
    import dcc_pkg::*;

    sample_t a_mag, b_mag;
    logic    a_valid, b_valid;
    sample_t a_pre_peak, a_peak_tap, a_post_peak, a_tail_tap;  // channel a taps
    sample_t b_pre_peak, b_peak_tap, b_post_peak, b_tail_tap;  // channel b taps
    sample_t a_peak_val, a_tail_val, b_peak_val, b_tail_val;   // captured values
    logic    b_hit;
    logic    arm;
    tick_t   event_time;

    // ========================================
    // input side and histories
    // ========================================
    adc_capture u_capture (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .ada_d(ada_d), .adb_d(adb_d),
        .a_mag(a_mag), .a_valid(a_valid), .b_mag(b_mag), .b_valid(b_valid)
    );

    pulse_history u_hist_a (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .mag(a_mag), .valid(a_valid),
        .pre_peak(a_pre_peak), .peak(a_peak_tap), .post_peak(a_post_peak), .tail(a_tail_tap)
    );

    pulse_history u_hist_b (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .mag(b_mag), .valid(b_valid),
        .pre_peak(b_pre_peak), .peak(b_peak_tap), .post_peak(b_post_peak), .tail(b_tail_tap)
    );

    // ========================================
    // detection, timing, readout
    // ========================================
    peak_detector #(.GAIN(CH_A_GAIN)) u_peak_a (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .valid(a_valid), .arm(arm),
        .pre_peak(a_pre_peak), .peak(a_peak_tap), .post_peak(a_post_peak), .tail(a_tail_tap),
        .peak_value(a_peak_val), .tail_value(a_tail_val),
        .hit()                                 // a hits do not touch dead time
    );

    peak_detector #(.GAIN(CH_B_GAIN)) u_peak_b (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .valid(b_valid), .arm(arm),
        .pre_peak(b_pre_peak), .peak(b_peak_tap), .post_peak(b_post_peak), .tail(b_tail_tap),
        .peak_value(b_peak_val), .tail_value(b_tail_val),
        .hit(b_hit)
    );

    trigger_timing u_timing (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .b_valid(b_valid), .b_hit(b_hit), .arm(arm), .event_time(event_time)
    );

    readout_port u_readout (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .read_req(read_req), .read_ack(read_ack),
        .a_peak(a_peak_val), .b_peak(b_peak_val), .a_tail(a_tail_val), .b_tail(b_tail_val),
        .event_time(event_time),
        .peak_word(peak_word), .tail_word(tail_word), .time_word(time_word)
    );

endmodule

// File: peak_detector.sv
`timescale 1ns/1ps

module peak_detector #(
    parameter int GAIN = dcc_pkg::CH_A_GAIN
) (
    input  logic             ADA_DCO,
    input  logic             hps_fpga_reset_n,
    input  logic             valid,
    input  logic             arm,
    input  dcc_pkg::sample_t pre_peak,
    input  dcc_pkg::sample_t peak,
    input  dcc_pkg::sample_t post_peak,
    input  dcc_pkg::sample_t tail,
    output dcc_pkg::sample_t peak_value,
    output dcc_pkg::sample_t tail_value,
    output logic             hit
);
    import dcc_pkg::*;

    word_t scaled;     // peak times gain, wide enough for any channel
    logic  is_max;     // local maximum over three taps
    logic  above;      // over the scaled threshold
    logic  fire;       // all gates met this cycle

    // ========================================
    // gates
    // ========================================
    assign scaled = word_t'(peak) * word_t'(GAIN);
    assign is_max = (pre_peak <= peak) && (peak >= post_peak);
    assign above  = scaled > PEAK_THRESHOLD;
    assign fire   = valid && arm && is_max && above;

    // capture registers, one cycle behind the gate
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            peak_value <= '0;
            tail_value <= '0;
            hit        <= 1'b0;
        end
        else
        begin
            hit <= fire;                      // single-cycle pulse
            if (fire)
            begin
                if (peak < PEAK_MAX)
                begin
                    peak_value <= peak;
                    tail_value <= tail;
                end
                else                          // saturated pulse, record zero
                begin
                    peak_value <= '0;
                    tail_value <= '0;
                end
            end
        end
    end

endmodule

// File: pulse_history.sv
`timescale 1ns/1ps

module pulse_history (
    input  logic             ADA_DCO,
    input  logic             hps_fpga_reset_n,
    input  dcc_pkg::sample_t mag,
    input  logic             valid,
    output dcc_pkg::sample_t pre_peak,
    output dcc_pkg::sample_t peak,
    output dcc_pkg::sample_t post_peak,
    output dcc_pkg::sample_t tail
);
    import dcc_pkg::*;

    sample_t hist [HIST_DEPTH];    // [0] newest, [HIST_DEPTH-1] oldest

    // ========================================
    // delay line
    // ========================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            for (int i = 0; i < HIST_DEPTH; i++)
            begin
                hist[i] <= '0;
            end
        end
        else if (valid)            // only kept samples advance the line
        begin
            for (int i = HIST_DEPTH - 1; i > 0; i--)
            begin
                hist[i] <= hist[i-1];
            end
            hist[0] <= mag;        // new magnitude enters at the front
        end
    end

    // taps read the line before this edge's shift
    assign pre_peak  = hist[PEAK_TAP+1];  // oldest entry, one before the peak
    assign peak      = hist[PEAK_TAP];
    assign post_peak = hist[PEAK_TAP-1];  // one newer than the peak
    assign tail      = hist[TAIL_TAP];    // near the newest end

endmodule

// File: readout_port.sv
`timescale 1ns/1ps

module readout_port (
    input  logic             ADA_DCO,
    input  logic             hps_fpga_reset_n,
    input  logic             read_req,
    output logic             read_ack,
    input  dcc_pkg::sample_t a_peak,
    input  dcc_pkg::sample_t b_peak,
    input  dcc_pkg::sample_t a_tail,
    input  dcc_pkg::sample_t b_tail,
    input  dcc_pkg::tick_t   event_time,
    output dcc_pkg::word_t   peak_word,
    output dcc_pkg::word_t   tail_word,
    output dcc_pkg::tick_t   time_word
);
    import dcc_pkg::*;

    logic take;    // new request seen this edge

    // channel a low, channel b at CH_B_LSB, spare bits zero
    function automatic word_t pack(input sample_t lo, input sample_t hi);
        word_t w;
        w                       = '0;
        w[ADC_BITS-1:0]         = lo;
        w[CH_B_LSB +: ADC_BITS] = hi;
        return w;
    endfunction

    assign take = read_req && !read_ack;

    // ========================================
    // four-phase handshake and snapshot
    // ========================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            read_ack  <= 1'b0;
            peak_word <= '0;
            tail_word <= '0;
            time_word <= '0;
        end
        else if (take)
        begin
            read_ack  <= 1'b1;                 // ack with the snapshot
            peak_word <= pack(a_peak, b_peak);
            tail_word <= pack(a_tail, b_tail);
            time_word <= event_time;
        end
        else if (!read_req)
        begin
            read_ack <= 1'b0;                  // host dropped req, release
        end
        // req held with ack high: snapshot stays frozen
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and judge the log

rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dcc_trigger -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// File: tb.f
+incdir+.
dcc_pkg.sv
adc_capture.sv
pulse_history.sv
peak_detector.sv
trigger_timing.sv
readout_port.sv
dcc_trigger_top.sv
tb_dcc_trigger.sv

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;    // wrong data or ack level
int proto_errors = 0;    // handshake edges that never came

// ========================================
// compare tasks, one per result type
// ========================================
task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp)
    begin
        value_errors++;
        $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
        value_errors++;
        $display("Fail %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
endtask

task automatic check_tick(input tick_t got, input tick_t exp, input string what);
    if (got !== exp)
    begin
        value_errors++;
        $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

`endif

// File: tb_dcc_trigger.sv
`timescale 1ns/1ps

module tb_dcc_trigger;
    import dcc_pkg::*;

    localparam int PERIOD       = 100;
    localparam int ACK_WAIT     = 8;                 // cycles allowed per handshake edge
    localparam int PULSE_CYCLES = HIST_DEPTH + 13;   // shape plus flush past the peak tap
    localparam int RUN_CYCLES   = 205 + 3 * DEAD_SAMPLES + 10 * PULSE_CYCLES
                                  + 8 * (2 * ACK_WAIT + 2);

    logic     ADA_DCO = 1'b0;
    logic     hps_fpga_reset_n;
    adc_raw_t ada_d;
    adc_raw_t adb_d;
    logic     read_req;
    logic     read_ack;
    word_t    peak_word;
    word_t    tail_word;
    tick_t    time_word;

    // model state with one variable per pipeline register
    sample_t m_ha [HIST_DEPTH];
    sample_t m_hb [HIST_DEPTH];
    sample_t m_a_mag, m_b_mag, m_a_pk, m_a_tl, m_b_pk, m_b_tl;
    logic    m_a_val, m_b_val, m_b_hit, m_arm, m_ack;
    int      m_dead;                                 // b samples since last b hit
    tick_t   m_tick, m_evt, m_time_w;
    word_t   m_peak_w, m_tail_w;

    `include "tb_checks.svh"

    dcc_trigger_top uut (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .ada_d(ada_d), .adb_d(adb_d), .read_req(read_req), .read_ack(read_ack),
        .peak_word(peak_word), .tail_word(tail_word), .time_word(time_word)
    );

    always #(PERIOD / 2) ADA_DCO = ~ADA_DCO;

    // three-tap local maximum over the scaled threshold
    function automatic logic local_peak(input sample_t pre, input sample_t pk,
                                        input sample_t post, input int gain);
        return (pre <= pk) && (pk >= post) && (int'(pk) * gain > PEAK_THRESHOLD);
    endfunction

    // ========================================
    // reference model stepped on each rising edge
    // ========================================
    always @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin : model_step
        logic fa;
        logic fb;
        if (!hps_fpga_reset_n)
        begin
            m_ha = '{default: '0};
            m_hb = '{default: '0};
            {m_a_mag, m_b_mag, m_a_pk, m_a_tl, m_b_pk, m_b_tl} = '0;
            {m_a_val, m_b_val, m_b_hit, m_arm, m_ack} = '0;
            {m_tick, m_evt, m_time_w, m_peak_w, m_tail_w} = '0;
            m_dead = 0;
        end
        else
        begin
            // stages run back to front so each sees the values before this edge
            if (read_req && !m_ack)
            begin
                m_ack    = 1'b1;
                m_peak_w = {2'b00, m_b_pk, 2'b00, m_a_pk};   // b at bit 16 and a at bit 0
                m_tail_w = {2'b00, m_b_tl, 2'b00, m_a_tl};
                m_time_w = m_evt;
            end
            else if (!read_req)
                m_ack = 1'b0;
            fa = m_a_val && m_arm && local_peak(m_ha[PEAK_TAP+1], m_ha[PEAK_TAP],
                                                m_ha[PEAK_TAP-1], CH_A_GAIN);
            fb = m_b_val && m_arm && local_peak(m_hb[PEAK_TAP+1], m_hb[PEAK_TAP],
                                                m_hb[PEAK_TAP-1], CH_B_GAIN);
            m_arm = m_dead > DEAD_SAMPLES;                   // from the old count
            if (m_b_hit)
            begin
                m_evt  = m_tick;
                m_dead = 0;
            end
            else if (m_b_val && m_dead <= DEAD_SAMPLES)
                m_dead = m_dead + 1;
            m_tick  = (int'(m_tick) == TICK_WRAP) ? '0 : m_tick + 1'b1;
            m_b_hit = fb;
            if (fa)
            begin
                m_a_pk = (int'(m_ha[PEAK_TAP]) < PEAK_MAX) ? m_ha[PEAK_TAP] : '0;
                m_a_tl = (int'(m_ha[PEAK_TAP]) < PEAK_MAX) ? m_ha[TAIL_TAP] : '0;
            end
            if (fb)
            begin
                m_b_pk = (int'(m_hb[PEAK_TAP]) < PEAK_MAX) ? m_hb[PEAK_TAP] : '0;
                m_b_tl = (int'(m_hb[PEAK_TAP]) < PEAK_MAX) ? m_hb[TAIL_TAP] : '0;
            end
            for (int i = HIST_DEPTH - 1; i > 0; i--)
            begin
                if (m_a_val) m_ha[i] = m_ha[i-1];
                if (m_b_val) m_hb[i] = m_hb[i-1];
            end
            if (m_a_val) m_ha[0] = m_a_mag;
            if (m_b_val) m_hb[0] = m_b_mag;
            m_a_val = int'(ada_d) >= NEG_LIMIT;              // negative codes only
            m_b_val = int'(adb_d) >= NEG_LIMIT;
            if (m_a_val) m_a_mag = sample_t'(FULL_SCALE - int'(ada_d));
            if (m_b_val) m_b_mag = sample_t'(FULL_SCALE - int'(adb_d));
        end
    end

    // outputs are settled at the falling edge
    always @(negedge ADA_DCO)
    begin
        if (hps_fpga_reset_n)
        begin
            if (read_ack !== m_ack)
            begin
                value_errors++;
                $display("Fail %0t ns: read_ack is %b, expected %b", $time, read_ack, m_ack);
            end
            check_word(peak_word, m_peak_w, "peak_word");
            check_word(tail_word, m_tail_w, "tail_word");
            check_tick(time_word, m_time_w, "time_word");
        end
    end

    // ========================================
    // stimulus helpers
    // ========================================
    function automatic int noise_mag();
        return int'($urandom % 200) + 1;                     // too small to trigger
    endfunction

    // magnitude 0 asks for a random positive code
    task automatic step(input int a_mag, input int b_mag);
        @(negedge ADA_DCO);
        ada_d = (a_mag > 0) ? adc_raw_t'(FULL_SCALE - a_mag) : adc_raw_t'($urandom % NEG_LIMIT);
        adb_d = (b_mag > 0) ? adc_raw_t'(FULL_SCALE - b_mag) : adc_raw_t'($urandom % NEG_LIMIT);
    endtask

    task automatic noise(input int n);
        repeat (n) step(noise_mag(), noise_mag());
    endtask

    // five-sample pulse on one channel followed by a flush past the peak tap
    task automatic pulse(input logic on_b, input int h);
        int shape [5];
        shape = '{h / 4, h / 2, h, h / 2, h / 4};
        foreach (shape[i])
        begin
            if (on_b) step(noise_mag(), shape[i]);
            else step(shape[i], noise_mag());
        end
        noise(HIST_DEPTH + 8);
    endtask

    task automatic raise_req();
        int n;
        @(negedge ADA_DCO);
        read_req = 1'b1;
        n = 0;
        while (read_ack !== 1'b1 && n < ACK_WAIT)
        begin
            @(negedge ADA_DCO);
            n++;
        end
        if (read_ack !== 1'b1)
        begin
            proto_errors++;
            $display("handshake: read_ack did not rise within %0d cycles of read_req", ACK_WAIT);
        end
    endtask

    task automatic drop_req();
        int n;
        @(negedge ADA_DCO);
        read_req = 1'b0;
        n = 0;
        while (read_ack !== 1'b0 && n < ACK_WAIT)
        begin
            @(negedge ADA_DCO);
            n++;
        end
        if (read_ack !== 1'b0)
        begin
            proto_errors++;
            $display("handshake: read_ack stayed high %0d cycles after read_req fell", ACK_WAIT);
        end
    endtask

    task automatic read_snapshot();
        raise_req();
        drop_req();
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial
    begin
        void'($urandom(32'hb2a4));
        hps_fpga_reset_n = 1'b0;
        ada_d            = '0;
        adb_d            = '0;
        read_req         = 1'b0;
        repeat (5) @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;

        if (read_ack !== 1'b0)
        begin
            value_errors++;
            $display("Fail %0t ns: read_ack high after reset", $time);
        end
        read_snapshot();
        check_word(peak_word, '0, "peak_word after reset");
        check_word(tail_word, '0, "tail_word after reset");
        check_tick(time_word, '0, "time_word after reset");

        repeat (200) step(0, 0);                 // positive codes never enter the history
        pulse(1'b0, 5000);                       // dead time not yet over
        pulse(1'b1, 2000);
        pulse(1'b0, 2000);
        read_snapshot();
        check_word(peak_word, '0, "peak_word before arming");
        check_word(tail_word, '0, "tail_word before arming");

        noise(DEAD_SAMPLES);                     // arm
        pulse(1'b0, 3500);
        pulse(1'b1, 2000);                       // b hit restarts dead time
        pulse(1'b0, 4000);                       // so this one is ignored
        read_snapshot();
        check_sample(peak_word[ADC_BITS-1:0], 14'd3500, "a peak");
        check_sample(peak_word[CH_B_LSB +: ADC_BITS], 14'd2000, "b peak");
        check_tick(time_word, m_evt, "timestamp of last b hit");

        noise(DEAD_SAMPLES);
        pulse(1'b0, 300);                        // under threshold at gain 1
        pulse(1'b1, 300);                        // over it at gain 12
        read_snapshot();
        check_sample(peak_word[ADC_BITS-1:0], 14'd3500, "a peak after small pulse");
        check_sample(peak_word[CH_B_LSB +: ADC_BITS], 14'd300, "b peak small pulse");

        noise(DEAD_SAMPLES);
        pulse(1'b0, 8100);                       // saturated
        read_snapshot();
        check_sample(peak_word[ADC_BITS-1:0], 14'd0, "saturated a peak");
        check_sample(tail_word[ADC_BITS-1:0], 14'd0, "saturated a tail");

        raise_req();                             // hold the request across a new b hit
        pulse(1'b1, 2500);
        check_sample(peak_word[CH_B_LSB +: ADC_BITS], 14'd300, "b peak while req held");
        drop_req();
        read_snapshot();
        check_sample(peak_word[CH_B_LSB +: ADC_BITS], 14'd2500, "b peak after release");
        check_tick(time_word, m_evt, "timestamp after release");

        $display("errors: %0d value mismatches, %0d handshake timeouts",
                 value_errors, proto_errors);
        if (value_errors + proto_errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog sized from the sequence above
    initial
    begin
        #((RUN_CYCLES + 500) * PERIOD);
        $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES + 500);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: trigger_timing.sv
`timescale 1ns/1ps

module trigger_timing (
    input  logic           ADA_DCO,
    input  logic           hps_fpga_reset_n,
    input  logic           b_valid,
    input  logic           b_hit,
    output logic           arm,
    output dcc_pkg::tick_t event_time
);
    import dcc_pkg::*;

    tick_t                tick;        // free running timebase
    logic [DEAD_BITS-1:0] dead_cnt;    // b samples since last b hit

    // ========================================
    // tick counter
    // ========================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            tick <= '0;
        end
        else if (tick == TICK_WRAP)
        begin
            tick <= '0;                // wrap, same period as the board timer
        end
        else
        begin
            tick <= tick + 1'b1;
        end
    end

    // ========================================
    // dead time and timestamp
    // ========================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            dead_cnt   <= '0;
            arm        <= 1'b0;
            event_time <= '0;
        end
        else
        begin
            if (b_hit)
            begin
                dead_cnt   <= '0;      // restart dead time
                event_time <= tick;    // stamp the event
            end
            else if (b_valid && (dead_cnt < DEAD_SAMPLES + 1))
            begin
                dead_cnt <= dead_cnt + 1'b1;  // saturates one past the limit
            end
            arm <= dead_cnt > DEAD_SAMPLES;
        end
    end

endmodule
